//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- fetch_unit.f
+incdir+source
source/core_defs_pkg.sv
source/bus_defs_pkg.sv
source/inst_expander.sv
source/fetch_apb_master.sv
source/fetch_parcel_buffer.sv
source/fetch_unit.sv
testbench/tb_apb_rom.sv
testbench/tb_fetch_unit.sv

//--- source/bus_defs_pkg.sv
`include "fetch_config.svh"

package bus_defs_pkg;

    // requester side of an apb transfer
    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`FETCH_ADDR_W-1:0] paddr;
        logic [31:0]              pwdata;
    } apb_req_t;

    // completer side
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_phase_e;

endpackage

//--- source/core_defs_pkg.sv
package core_defs_pkg;

    // rv32i major opcodes, bits 6:0 of every base instruction
    typedef enum logic [6:0] {
        load     = 7'b000_0011,
        misc_mem = 7'b000_1111,
        op_imm   = 7'b001_0011,
        auipc    = 7'b001_0111,
        store    = 7'b010_0011,
        op       = 7'b011_0011,
        lui      = 7'b011_0111,
        branch   = 7'b110_0011,
        jalr     = 7'b110_0111,
        jal      = 7'b110_1111,
        system   = 7'b111_0011
    } opcode_e;

    // r-type field layout
    // other formats reuse the same bit positions for immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_t;

    // one instruction handed to decode
    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;
        logic        is_compressed;
        logic        illegal;
    } fetch_out_t;

endpackage

//--- source/fetch_apb_master.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_apb_master (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  logic                   i_space,
    input  logic                   i_redirect_valid,
    input  logic [31:0]            i_redirect_pc,
    output bus_defs_pkg::apb_req_t o_apb,
    input  bus_defs_pkg::apb_rsp_t i_apb,
    output logic                   o_word_valid,
    output logic [31:0]            o_word_data,
    output logic [31:0]            o_word_addr
);
    import bus_defs_pkg::*;

    localparam logic [31:0] reset_word = `FETCH_RESET_PC & 32'hffff_fffc;

    apb_phase_e  phase;
    logic [31:0] next_addr;
    logic [31:0] req_addr;
    logic        discard;
    logic        done;
    logic        start;

    assign done = (phase == access) && i_apb.pready;
    // back-to-back reads: a new setup may follow the completing access
    assign start = i_space && !i_redirect_valid && ((phase == idle) || done);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= idle;
            next_addr <= reset_word;
            req_addr  <= reset_word;
            discard   <= 1'b0;
        end else begin
            case (phase)
                idle:    phase <= start ? setup : idle;
                setup:   phase <= access;
                access:  phase <= done ? (start ? setup : idle) : access;
                default: phase <= idle;
            endcase

            if (start) begin
                req_addr <= next_addr;
            end

            if (i_redirect_valid) begin
                next_addr <= {i_redirect_pc[31:2], 2'b00};
            end else if (start) begin
                next_addr <= next_addr + 32'd4;
            end

            // the bus transfer still runs to completion, only its data is dropped
            if (i_redirect_valid && (phase != idle) && !done) begin
                discard <= 1'b1;
            end else if (done) begin
                discard <= 1'b0;
            end
        end
    end

    assign o_word_valid = done && !discard && !i_redirect_valid;
    assign o_word_data  = i_apb.prdata;
    assign o_word_addr  = req_addr;

    always_comb begin
        o_apb         = '0;
        o_apb.psel    = (phase != idle);
        o_apb.penable = (phase == access);
        o_apb.paddr   = req_addr[`FETCH_ADDR_W-1:0];
    end

    a_paddr_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_apb.penable |-> $stable(o_apb.paddr));

    // a setup cycle is always followed by its access cycle with psel held
    a_penable_in_psel: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_apb.psel && !o_apb.penable |=> o_apb.psel && o_apb.penable);

endmodule

//--- source/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// parcel queue capacity in halfwords
// any even value of 4 or more works
`define FETCH_BUF_PARCELS 6

// apb address width on the memory side
`define FETCH_ADDR_W 32

`endif

//--- source/fetch_parcel_buffer.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_parcel_buffer (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  logic                      i_word_valid,
    input  logic [31:0]               i_word_data,
    input  logic [31:0]               i_word_addr,
    output logic                      o_space,
    input  logic                      i_redirect_valid,
    input  logic [31:0]               i_redirect_pc,
    output logic [31:0]               o_window,
    input  core_defs_pkg::inst_t      i_inst,
    input  logic                      i_is_compressed,
    input  logic                      i_illegal,
    output core_defs_pkg::fetch_out_t o_fetch,
    output logic                      o_fetch_valid,
    input  logic                      i_fetch_ready
);
    import core_defs_pkg::*;

    localparam int depth = `FETCH_BUF_PARCELS;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    // at most one read is in flight, its two parcels are kept in reserve
    localparam int space_min = 4;

    logic [15:0]      parcels [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic [31:0]      head_pc;
    logic             skip_low;
    logic             push;
    logic [1:0]       push_n;
    logic [1:0]       pop_n;
    logic             have_inst;
    logic             load;
    fetch_out_t       out_q;
    logic             out_valid;

    function automatic logic [ptr_w-1:0] wrap_add(logic [ptr_w-1:0] p, logic [1:0] n);
        int sum;
        sum = int'(p) + int'(n);
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return ptr_w'(sum);
    endfunction

    // first word after a misaligned redirect: its low parcel is before the target
    assign skip_low = (count == '0) && head_pc[1] && (i_word_addr[31:2] == head_pc[31:2]);
    assign push     = i_word_valid && !i_redirect_valid;
    assign push_n   = !push ? 2'd0 : (skip_low ? 2'd1 : 2'd2);

    assign o_space  = (depth - int'(count)) >= space_min;
    assign o_window = {parcels[wrap_add(rd_ptr, 2'd1)], parcels[rd_ptr]};

    assign have_inst = (count >= cnt_w'(2)) || ((count == cnt_w'(1)) && i_is_compressed);
    assign load      = have_inst && (!out_valid || i_fetch_ready) && !i_redirect_valid;
    assign pop_n     = !load ? 2'd0 : (i_is_compressed ? 2'd1 : 2'd2);

    always_ff @(posedge i_clock) begin
        if (push) begin
            if (skip_low) begin
                parcels[wr_ptr] <= i_word_data[31:16];
            end else begin
                parcels[wr_ptr]                  <= i_word_data[15:0];
                parcels[wrap_add(wr_ptr, 2'd1)] <= i_word_data[31:16];
            end
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            head_pc   <= `FETCH_RESET_PC;
            out_valid <= 1'b0;
        end else if (i_redirect_valid) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            head_pc   <= {i_redirect_pc[31:1], 1'b0};
            out_valid <= 1'b0;
        end else begin
            wr_ptr <= wrap_add(wr_ptr, push_n);
            rd_ptr <= wrap_add(rd_ptr, pop_n);
            count  <= count + cnt_w'(push_n) - cnt_w'(pop_n);
            if (load) begin
                head_pc   <= head_pc + (i_is_compressed ? 32'd2 : 32'd4);
                out_valid <= 1'b1;
            end else if (i_fetch_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            out_q.pc            <= head_pc;
            out_q.inst          <= i_inst;
            out_q.is_compressed <= i_is_compressed;
            out_q.illegal       <= i_illegal;
        end
    end

    assign o_fetch       = out_q;
    assign o_fetch_valid = out_valid;

    // returns only arrive for reads started with space, so they always fit
    a_no_overflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_word_valid |-> (depth - int'(count)) >= int'(push_n));

    a_hold_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_fetch_valid && !i_fetch_ready && !i_redirect_valid
        |=> o_fetch_valid && $stable(o_fetch));

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  bus_defs_pkg::apb_rsp_t    i_apb,
    output bus_defs_pkg::apb_req_t    o_apb,
    input  logic                      i_redirect_valid,
    input  logic [31:0]               i_redirect_pc,
    output core_defs_pkg::fetch_out_t o_fetch,
    output logic                      o_fetch_valid,
    input  logic                      i_fetch_ready
);
    import core_defs_pkg::*;

    // word returns from the bus
    logic        word_valid;
    logic [31:0] word_data;
    logic [31:0] word_addr;
    logic        space;

    // oldest two parcels and their expansion
    logic [31:0] window;
    inst_t       exp_inst;
    logic        exp_compressed;
    logic        exp_illegal;

    fetch_apb_master u_master (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_space          (space),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .o_apb            (o_apb),
        .i_apb            (i_apb),
        .o_word_valid     (word_valid),
        .o_word_data      (word_data),
        .o_word_addr      (word_addr)
    );

    fetch_parcel_buffer u_buffer (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_word_valid     (word_valid),
        .i_word_data      (word_data),
        .i_word_addr      (word_addr),
        .o_space          (space),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .o_window         (window),
        .i_inst           (exp_inst),
        .i_is_compressed  (exp_compressed),
        .i_illegal        (exp_illegal),
        .o_fetch          (o_fetch),
        .o_fetch_valid    (o_fetch_valid),
        .i_fetch_ready    (i_fetch_ready)
    );

    inst_expander u_expander (
        .i_inst           (inst_t'(window)),
        .o_inst           (exp_inst),
        .o_is_compressed  (exp_compressed),
        .o_illegal        (exp_illegal)
    );

endmodule

//--- source/inst_expander.sv
`timescale 1ns/1ps

module inst_expander (
    input  core_defs_pkg::inst_t i_inst,
    output core_defs_pkg::inst_t o_inst,
    output logic                 o_is_compressed,
    output logic                 o_illegal
);
    import core_defs_pkg::*;

    logic [15:0] c;
    logic [4:0]  rd_f;
    logic [4:0]  rs2_f;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] imm_ci;
    logic [11:0] imm_lsw;
    logic [6:0]  alu_f7;
    logic [2:0]  alu_f3;
    inst_t       exp;
    logic        bad;

    // base format builders
    function automatic inst_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, opcode_e opc);
        return inst_t'({imm, rs1, f3, rd, opc});
    endfunction

    function automatic inst_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return inst_t'({f7, rs2, rs1, f3, rd, op});
    endfunction

    function automatic inst_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return inst_t'({imm[11:5], rs2, rs1, f3, imm[4:0], store});
    endfunction

    function automatic inst_t b_type(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
        return inst_t'({imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], branch});
    endfunction

    function automatic inst_t u_type(logic [19:0] imm, logic [4:0] rd);
        return inst_t'({imm, rd, lui});
    endfunction

    function automatic inst_t j_type(logic [20:0] imm, logic [4:0] rd);
        return inst_t'({imm[20], imm[10:1], imm[11], imm[19:12], rd, jal});
    endfunction

    assign c     = i_inst[15:0];
    assign rd_f  = c[11:7];
    assign rs2_f = c[6:2];
    // three-bit register fields map onto x8..x15
    assign rdp   = {2'b01, c[4:2]};
    assign rs1p  = {2'b01, c[9:7]};

    assign imm_ci  = {{7{c[12]}}, c[6:2]};
    assign imm_lsw = {5'b0, c[5], c[12:10], c[6], 2'b00};

    assign o_is_compressed = (c[1:0] != 2'b11);

    // c.sub, c.xor, c.or, c.and
    always_comb begin
        alu_f7 = 7'b000_0000;
        case (c[6:5])
            2'b00: begin
                alu_f7 = 7'b010_0000;
                alu_f3 = 3'b000;
            end
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
    end

    always_comb begin
        exp = i_inst;
        bad = 1'b0;
        case (c[1:0])
            2'b00: begin
                case (c[15:13])
                    // c.addi4spn
                    3'b000: begin
                        exp = i_type({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00},
                                     5'd2, 3'b000, rdp, op_imm);
                        bad = (c[12:5] == 8'd0);
                    end
                    3'b010:  exp = i_type(imm_lsw, rs1p, 3'b010, rdp, load);
                    3'b110:  exp = s_type(imm_lsw, rdp, rs1p, 3'b010);
                    // fp loads/stores and reserved slots
                    default: bad = 1'b1;
                endcase
            end
            2'b01: begin
                case (c[15:13])
                    3'b000: exp = i_type(imm_ci, rd_f, 3'b000, rd_f, op_imm);
                    // c.jal links to x1, c.j to x0
                    3'b001, 3'b101: begin
                        exp = j_type({{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11],
                                      c[5:3], 1'b0}, {4'b0, ~c[15]});
                    end
                    3'b010: begin
                        exp = i_type(imm_ci, 5'd0, 3'b000, rd_f, op_imm);
                        bad = (rd_f == 5'd0);
                    end
                    3'b011: begin
                        if (rd_f == 5'd2) begin
                            // c.addi16sp
                            exp = i_type({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0},
                                         5'd2, 3'b000, 5'd2, op_imm);
                        end else begin
                            exp = u_type({{14{c[12]}}, c[12], c[6:2]}, rd_f);
                        end
                        bad = ({c[12], c[6:2]} == 6'd0);
                    end
                    3'b100: begin
                        case (c[11:10])
                            // c.srli, c.srai; shamt[5] is reserved on rv32
                            2'b00, 2'b01: begin
                                exp = i_type({1'b0, c[10], 5'b0, c[6:2]}, rs1p, 3'b101,
                                             rs1p, op_imm);
                                bad = c[12];
                            end
                            2'b10:   exp = i_type(imm_ci, rs1p, 3'b111, rs1p, op_imm);
                            default: begin
                                exp = r_type(alu_f7, rdp, rs1p, alu_f3, rs1p);
                                bad = c[12];
                            end
                        endcase
                    end
                    // c.beqz and c.bnez, funct3 bit 0 from c[13]
                    default: begin
                        exp = b_type({{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0},
                                     rs1p, {2'b00, c[13]});
                    end
                endcase
            end
            2'b10: begin
                case (c[15:13])
                    3'b000: begin
                        exp = i_type({7'b0, c[6:2]}, rd_f, 3'b001, rd_f, op_imm);
                        bad = c[12];
                    end
                    3'b010: begin
                        exp = i_type({4'b0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'b010,
                                     rd_f, load);
                        bad = (rd_f == 5'd0);
                    end
                    3'b100: begin
                        if (rs2_f != 5'd0) begin
                            // c.mv uses x0 as rs1, c.add uses rd
                            exp = r_type(7'd0, rs2_f, c[12] ? rd_f : 5'd0, 3'b000, rd_f);
                        end else if (!c[12]) begin
                            exp = i_type(12'd0, rd_f, 3'b000, 5'd0, jalr);
                            bad = (rd_f == 5'd0);
                        end else if (rd_f == 5'd0) begin
                            exp = i_type(12'd1, 5'd0, 3'b000, 5'd0, system);
                        end else begin
                            exp = i_type(12'd0, rd_f, 3'b000, 5'd1, jalr);
                        end
                    end
                    3'b110:  exp = s_type({4'b0, c[8:7], c[12:9], 2'b00}, rs2_f, 5'd2, 3'b010);
                    default: bad = 1'b1;
                endcase
            end
            // full-width instruction, exp already holds the window
            default: bad = 1'b0;
        endcase
    end

    assign o_inst    = bad ? i_inst : exp;
    assign o_illegal = bad;

endmodule

//--- testbench/tb_apb_rom.sv
`timescale 1ns/1ps

module tb_apb_rom (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  bus_defs_pkg::apb_req_t i_apb,
    output bus_defs_pkg::apb_rsp_t o_apb
);
    import bus_defs_pkg::*;

    // 1 KB of word storage, written directly by the test tasks
    logic [31:0] mem [256];
    logic [1:0]  wait_left;

    // wait states are drawn during setup and counted down in access
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_left <= '0;
        end else if (i_apb.psel && !i_apb.penable) begin
            wait_left <= 2'($urandom % 4);
        end else if (i_apb.penable && (wait_left != 2'd0)) begin
            wait_left <= wait_left - 2'd1;
        end
    end

    always_comb begin
        o_apb         = '0;
        o_apb.pready  = i_apb.psel && i_apb.penable && (wait_left == 2'd0);
        o_apb.prdata  = mem[i_apb.paddr[9:2]];
        o_apb.pslverr = 1'b0;
    end

endmodule

//--- testbench/tb_fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_fetch_unit;
    import core_defs_pkg::*;
    import bus_defs_pkg::*;

    localparam int timeout_cycles = 200;

    logic        clock = 1'b0;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    fetch_out_t  fetch;
    logic        fetch_valid;
    logic        fetch_ready;

    // program image being built and the items decode should receive from it
    logic [15:0] prog[$];
    logic [31:0] prog_base;
    logic [31:0] prog_pc;
    fetch_out_t  expect_q[$];

    always #10 clock = ~clock;

    fetch_unit dut (
        .i_clock          (clock),
        .i_rst_n          (rst_n),
        .i_apb            (apb_rsp),
        .o_apb            (apb_req),
        .i_redirect_valid (redirect_valid),
        .i_redirect_pc    (redirect_pc),
        .o_fetch          (fetch),
        .o_fetch_valid    (fetch_valid),
        .i_fetch_ready    (fetch_ready)
    );

    tb_apb_rom rom (
        .i_clock (clock),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %08h got %08h", $time, name, exp, got));
        end
    endtask

    task automatic check_inst(string name, inst_t got, inst_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %08h got %08h", $time, name, exp, got));
        end
    endtask

    task automatic check_fetch(fetch_out_t got, fetch_out_t exp);
        check_word("o_fetch.pc", got.pc, exp.pc);
        check_inst("o_fetch.inst", got.inst, exp.inst);
        check_bit("o_fetch.is_compressed", got.is_compressed, exp.is_compressed);
        check_bit("o_fetch.illegal", got.illegal, exp.illegal);
    endtask

    // background words are 32-bit loads whose fields follow the address
    task automatic fill_background();
        for (int i = 0; i < 256; i++) begin
            rom.mem[8'(i)] = 32'h005a_0003 ^ (32'(i) << 24) ^ (32'(i) << 8);
        end
    endtask

    task automatic start_program(logic [31:0] pc);
        prog.delete();
        expect_q.delete();
        prog_base = {pc[31:2], 2'b00};
        prog_pc   = pc;
        // parcel below a misaligned start, decode must never see it
        if (pc[1]) begin
            prog.push_back(16'h0000);
        end
    endtask

    task automatic add_short(logic [15:0] raw, logic [31:0] expanded);
        fetch_out_t item;
        item.pc            = prog_pc;
        item.inst          = inst_t'(expanded);
        item.is_compressed = 1'b1;
        item.illegal       = 1'b0;
        prog.push_back(raw);
        expect_q.push_back(item);
        prog_pc = prog_pc + 32'd2;
    endtask

    task automatic add_long(logic [31:0] raw);
        fetch_out_t item;
        item.pc            = prog_pc;
        item.inst          = inst_t'(raw);
        item.is_compressed = 1'b0;
        item.illegal       = 1'b0;
        prog.push_back(raw[15:0]);
        prog.push_back(raw[31:16]);
        expect_q.push_back(item);
        prog_pc = prog_pc + 32'd4;
    endtask

    // the raw window is filled in once the image is complete
    task automatic add_illegal(logic [15:0] raw);
        fetch_out_t item;
        item.pc            = prog_pc;
        item.inst          = '0;
        item.is_compressed = 1'b1;
        item.illegal       = 1'b1;
        prog.push_back(raw);
        expect_q.push_back(item);
        prog_pc = prog_pc + 32'd2;
    endtask

    task automatic write_program();
        int         idx;
        logic [7:0] word_idx;
        // pad with c.nop to a whole word
        if ((prog.size() % 2) != 0) begin
            prog.push_back(16'h0001);
        end
        for (int k = 0; k < prog.size(); k += 2) begin
            word_idx = 8'((prog_base >> 2) + 32'(k / 2));
            rom.mem[word_idx] = {prog[k + 1], prog[k]};
        end
        foreach (expect_q[i]) begin
            if (expect_q[i].illegal) begin
                idx = int'((expect_q[i].pc - prog_base) >> 1);
                expect_q[i].inst = inst_t'({prog[idx + 1], prog[idx]});
            end
        end
    endtask

    // compressed forms with their rv32i expansions, longs placed to straddle words
    task automatic add_mixed_table();
        add_short(16'h0515, 32'h0055_0513);
        add_long(32'h1234_50b7);
        add_short(16'h4044, 32'h0044_2483);
        add_short(16'hc404, 32'h0094_2423);
        add_short(16'ha021, 32'h0080_006f);
        add_long(32'h0010_0093);
        add_short(16'hc011, 32'h0004_0263);
        add_short(16'h6585, 32'h0000_15b7);
        add_long(32'h0020_8113);
        add_short(16'h6141, 32'h0101_0113);
        add_short(16'h848d, 32'h4034_d493);
        add_short(16'h8c05, 32'h4094_0433);
        add_long(32'h0031_a023);
        add_short(16'h852e, 32'h00b0_0533);
        add_short(16'h952e, 32'h00b5_0533);
        add_short(16'h9082, 32'h0000_80e7);
        add_short(16'h4522, 32'h0081_2503);
        add_long(32'h0000_0073);
        add_short(16'hc62e, 32'h00b1_2623);
        add_short(16'h9002, 32'h0010_0073);
    endtask

    task automatic redirect_to(logic [31:0] target);
        redirect_pc    = target;
        redirect_valid = 1'b1;
        @(posedge clock);
        #1;
        redirect_valid = 1'b0;
        check_bit("o_fetch_valid", fetch_valid, 1'b0);
    endtask

    task automatic receive(output fetch_out_t item);
        int waited;
        waited      = 0;
        fetch_ready = 1'b1;
        while (!fetch_valid) begin
            @(posedge clock);
            #1;
            waited = waited + 1;
            if (waited > timeout_cycles) begin
                abort_run("timed out waiting for o_fetch_valid");
            end
        end
        item = fetch;
        @(posedge clock);
        #1;
        fetch_ready = 1'b0;
    endtask

    // ready low while the held item must not change
    task automatic stall_cycles(int cycles);
        fetch_out_t held;
        logic       was_valid;
        was_valid   = fetch_valid;
        held        = fetch;
        fetch_ready = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            #1;
            if (was_valid) begin
                check_bit("o_fetch_valid", fetch_valid, 1'b1);
                check_fetch(fetch, held);
            end else begin
                was_valid = fetch_valid;
                held      = fetch;
            end
        end
    endtask

    task automatic drain(int count, logic with_stalls);
        fetch_out_t got;
        for (int i = 0; i < count; i++) begin
            if (with_stalls) begin
                stall_cycles(int'($urandom % 11));
            end
            receive(got);
            check_fetch(got, expect_q[i]);
        end
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clock);
            #1;
            check_bit("o_fetch_valid", fetch_valid, 1'b0);
            check_bit("o_apb.psel", apb_req.psel, 1'b0);
            check_bit("o_apb.penable", apb_req.penable, 1'b0);
        end
        rst_n = 1'b1;
        check_bit("o_apb.psel", apb_req.psel, 1'b0);
        @(posedge clock);
        #1;
        check_bit("o_apb.psel", apb_req.psel, 1'b1);
        check_bit("o_apb.penable", apb_req.penable, 1'b0);
        check_bit("o_apb.pwrite", apb_req.pwrite, 1'b0);
        check_word("o_apb.pwdata", apb_req.pwdata, 32'h0000_0000);
        check_word("o_apb.paddr", apb_req.paddr, `FETCH_RESET_PC & 32'hffff_fffc);
        @(posedge clock);
        #1;
        check_bit("o_apb.penable", apb_req.penable, 1'b1);
        check_bit("o_apb.pwrite", apb_req.pwrite, 1'b0);
        check_word("o_apb.pwdata", apb_req.pwdata, 32'h0000_0000);
        check_word("o_apb.paddr", apb_req.paddr, `FETCH_RESET_PC & 32'hffff_fffc);
    endtask

    task automatic test_long_stream();
        start_program(32'h0000_0100);
        for (int i = 0; i < 8; i++) begin
            add_long(32'h0000_0013 | (32'(i + 1) << 20) | (32'(i) << 7));
        end
        write_program();
        redirect_to(32'h0000_0100);
        drain(expect_q.size(), 1'b0);
    endtask

    task automatic test_mixed_stream();
        start_program(32'h0000_0040);
        add_mixed_table();
        write_program();
        redirect_to(32'h0000_0040);
        drain(expect_q.size(), 1'b0);
    endtask

    // illegal parcels sit in low halves so the whole window comes from one word
    task automatic test_illegal();
        start_program(32'h0000_0080);
        add_illegal(16'h0000);
        add_short(16'h0515, 32'h0055_0513);
        add_illegal(16'h4002);
        add_short(16'h852e, 32'h00b0_0533);
        add_illegal(16'h0004);
        add_short(16'h952e, 32'h00b5_0533);
        write_program();
        redirect_to(32'h0000_0080);
        drain(expect_q.size(), 1'b0);
    endtask

    task automatic test_backpressure();
        start_program(32'h0000_0140);
        add_mixed_table();
        write_program();
        redirect_to(32'h0000_0140);
        drain(expect_q.size(), 1'b1);
    endtask

    task automatic test_redirect();
        start_program(32'h0000_0200);
        add_mixed_table();
        write_program();
        redirect_to(32'h0000_0200);
        drain(4, 1'b0);
        // new path opens with a long instruction across its first two words
        start_program(32'h0000_0302);
        add_long(32'h0050_0293);
        add_mixed_table();
        write_program();
        redirect_to(32'h0000_0302);
        drain(expect_q.size(), 1'b0);
    endtask

    initial begin
        #2_000_000;
        abort_run("simulation ran past its time limit");
    end

    initial begin
        void'($urandom(32'hb7af0a4d));
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fetch_ready    = 1'b0;
        fill_background();
        test_reset();
        test_long_stream();
        test_mixed_stream();
        test_illegal();
        test_backpressure();
        test_redirect();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
